/* files.f */
src/heapPkg.sv
src/arrayAllocator.sv
src/arraySizeTable.sv
src/elementStore.sv
src/elementAlu.sv
src/heapController.sv
src/arrayHeap.sv
sim/arrayHeapTb.sv

/* sim/arrayHeapTb.sv */
/*
  Table-driven testbench for the array heap. One command per row, issued
  back to back, result and error checked one cycle later.
  Expected values are worked out by hand from the command rules.
*/
`default_nettype none

module arrayHeapTb import heapPkg::*; ();

  localparam integer ResetTimeout = 50;                    // Cycles allowed for reset release

  typedef struct packed {
    heapAction_t               action;
    logic [HeapAddressBits-1:0] array;
    logic [HeapIndexBits-1:0]   index;
    logic [HeapDataBits-1:0]    data;
    logic [HeapDataBits-1:0]    expResult;
    heapError_t                 expError;
  } testRow_t;

  logic                    clock;
  logic                    resetN;
  heapRequest_t            request;
  logic [HeapDataBits-1:0] result;
  heapError_t              error;
  testRow_t                rows [$];

  arrayHeap u_arrayHeap (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .result  (result),
    .error   (error)
  );

  always #10 clock = ~clock;

  // Helpers --------------------
  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected)
      stopWithFailure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
  endtask

  task automatic addRow(input heapAction_t action, input logic [HeapAddressBits-1:0] array,
                        input logic [HeapIndexBits-1:0] index,
                        input logic [HeapDataBits-1:0] data,
                        input logic [HeapDataBits-1:0] expResult, input heapError_t expError);
    testRow_t row;
    row.action    = action;
    row.array     = array;
    row.index     = index;
    row.data      = data;
    row.expResult = expResult;
    row.expError  = expError;
    rows.push_back(row);
  endtask

  // Command table --------------------
  task automatic buildTable();
    // Allocation order and reuse of freed arrays
    addRow(actAlloc,  0, 0, 12'h000, 12'h000, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h001, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h002, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h003, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h003, errOutOfMemory);
    addRow(actFree,   1, 0, 12'h000, 12'h003, errNone);
    addRow(actFree,   3, 0, 12'h000, 12'h003, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h003, errNone);   // Last freed comes back first
    addRow(actAlloc,  0, 0, 12'h000, 12'h001, errNone);
    addRow(actFree,   2, 0, 12'h000, 12'h001, errNone);
    addRow(actFree,   2, 0, 12'h000, 12'h001, errFreed);
    // Write, read, bounds
    addRow(actWrite,  0, 0, 12'h00B, 12'h00B, errNone);
    addRow(actWrite,  0, 1, 12'h016, 12'h016, errNone);
    addRow(actRead,   0, 0, 12'h000, 12'h00B, errNone);
    addRow(actRead,   0, 1, 12'h000, 12'h016, errNone);
    addRow(actRead,   0, 2, 12'h000, 12'h016, errOutOfBounds);
    addRow(actIdle,   0, 0, 12'h000, 12'h016, errOutOfBounds);  // Both outputs hold
    addRow(actSize,   0, 0, 12'h000, 12'h002, errNone);
    // Push, pop, inc, dec, resize on array 3
    addRow(actPush,   3, 0, 12'h100, 12'h002, errNone);
    addRow(actPush,   3, 0, 12'h200, 12'h002, errNone);
    addRow(actPush,   3, 0, 12'h300, 12'h002, errNone);
    addRow(actPush,   3, 0, 12'h400, 12'h002, errNone);
    addRow(actPush,   3, 0, 12'h500, 12'h002, errFull);
    addRow(actInc,    3, 0, 12'h000, 12'h002, errFull);
    addRow(actPop,    3, 0, 12'h000, 12'h400, errNone);
    addRow(actPop,    3, 0, 12'h000, 12'h300, errNone);
    addRow(actPop,    3, 0, 12'h000, 12'h200, errNone);
    addRow(actPop,    3, 0, 12'h000, 12'h100, errNone);
    addRow(actPop,    3, 0, 12'h000, 12'h100, errEmpty);
    addRow(actDec,    3, 0, 12'h000, 12'h100, errEmpty);
    addRow(actInc,    3, 0, 12'h000, 12'h100, errNone);
    addRow(actDec,    3, 0, 12'h000, 12'h100, errNone);
    addRow(actResize, 3, 0, 12'h005, 12'h100, errTooLarge);
    addRow(actResize, 3, 0, 12'h003, 12'h100, errNone);
    addRow(actSize,   3, 0, 12'h000, 12'h003, errNone);
    // Element operations on array 0, index 0
    addRow(actWrite,      0, 0, 12'hFF0, 12'hFF0, errNone);
    addRow(actAdd,        0, 0, 12'h020, 12'h010, errNone);   // Wraps past 12 bits
    addRow(actAddAfter,   0, 0, 12'h005, 12'h010, errNone);
    addRow(actRead,       0, 0, 12'h000, 12'h015, errNone);
    addRow(actSub,        0, 0, 12'h020, 12'hFF5, errNone);   // Wraps below zero
    addRow(actSubAfter,   0, 0, 12'h0F5, 12'hFF5, errNone);
    addRow(actRead,       0, 0, 12'h000, 12'hF00, errNone);
    addRow(actShr,        0, 0, 12'h004, 12'h0F0, errNone);
    addRow(actShl,        0, 0, 12'h002, 12'h3C0, errNone);
    addRow(actNotLogical, 0, 0, 12'h000, 12'h000, errNone);
    addRow(actNotLogical, 0, 0, 12'h000, 12'h001, errNone);
    addRow(actNot,        0, 0, 12'h000, 12'hFFE, errNone);
    addRow(actOr,         0, 0, 12'h001, 12'hFFF, errNone);
    addRow(actXor,        0, 0, 12'h0F0, 12'hF0F, errNone);
    addRow(actAnd,        0, 0, 12'h0FF, 12'h00F, errNone);
    addRow(actRead,       0, 0, 12'h000, 12'h00F, errNone);
    addRow(actAdd,        0, 3, 12'h001, 12'h00F, errOutOfBounds);
    // Reset action clears allocation and sizes
    addRow(actReset,  0, 0, 12'h000, 12'h00F, errNone);
    addRow(actAlloc,  0, 0, 12'h000, 12'h000, errNone);
    addRow(actRead,   0, 0, 12'h000, 12'h000, errOutOfBounds);
    addRow(actRead,   1, 0, 12'h000, 12'h000, errNotAllocated);
    addRow(actSize,   0, 0, 12'h000, 12'h000, errNone);
  endtask

  // Reset --------------------
  initial begin
    int cycle;
    clock   = 1'b0;
    resetN  = 1'b0;
    request = '0;
    for (cycle = 0; cycle < 10; cycle++) @(posedge clock);
    #2 resetN = 1'b1;
  end

  // Main sequence --------------------
  initial begin
    int waited;
    waited = 0;
    buildTable();
    while (resetN !== 1'b1) begin
      @(posedge clock);
      waited++;
      if (waited > ResetTimeout)
        stopWithFailure("Timed out waiting for reset to be released");
    end
    #2;
    checkValue("result after reset", 16'h0000, result);
    checkValue("error after reset", errNone, error);

    foreach (rows[r]) begin
      request.action = rows[r].action;
      request.array  = rows[r].array;
      request.index  = rows[r].index;
      request.data   = rows[r].data;
      @(posedge clock);
      #2;
      checkValue($sformatf("result, row %0d", r), rows[r].expResult, result);
      checkValue($sformatf("error, row %0d", r), rows[r].expError, error);
    end
    request = '0;

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/arrayHeap.sv */
/*
  Array heap top. One command per clock, no handshake.
  A nonzero action is executed at the next rising edge.
*/
`default_nettype none

module arrayHeap import heapPkg::*; (
  input  wire                        clock,
  input  wire                        resetN,
  input  wire heapRequest_t          request,
  output logic [HeapDataBits-1:0]    result,
  output heapError_t                 error
);

  arrayStatus_t               arrayStatus;
  sizeStatus_t                sizeStatus;
  logic                       outOfMemory;
  logic [HeapAddressBits-1:0] newArray;
  logic [HeapDataBits-1:0]    readValue;
  logic [HeapDataBits-1:0]    topValue;
  logic [HeapDataBits-1:0]    newValue;
  logic [HeapDataBits-1:0]    returnValue;
  logic                       allocCommit;
  logic                       sizeCommit;
  logic                       storeWrite;
  logic [HeapIndexBits-1:0]   writeIndex;
  logic [HeapDataBits-1:0]    writeValue;
  logic [HeapIndexBits-1:0]   topIndex;

  heapController u_heapController (
    .clock, .resetN, .request, .arrayStatus, .sizeStatus, .outOfMemory, .newArray,
    .readValue, .topValue, .newValue, .returnValue, .result, .error,
    .allocCommit, .sizeCommit, .storeWrite, .writeIndex, .writeValue, .topIndex
  );

  arrayAllocator u_arrayAllocator (
    .clock, .resetN, .request, .allocCommit, .arrayStatus, .newArray, .outOfMemory
  );

  arraySizeTable u_arraySizeTable (
    .clock, .resetN, .request, .sizeCommit, .newArray, .sizeStatus
  );

  elementStore u_elementStore (
    .clock, .request, .storeWrite, .writeIndex, .writeValue, .readValue, .topValue, .topIndex
  );

  elementAlu u_elementAlu (
    .request, .readValue, .newValue, .returnValue
  );

endmodule

`default_nettype wire

/* src/heapController.sv */
/*
  Command decode, error priority and commit gating.
  Result and error are registered, one cycle after the command.
  Idle cycles and failed commands leave the result as it was.
*/
`default_nettype none

module heapController import heapPkg::*; (
  input  wire                             clock,
  input  wire                             resetN,
  input  wire heapRequest_t               request,
  input  wire arrayStatus_t               arrayStatus,
  input  wire sizeStatus_t                sizeStatus,
  input  wire                             outOfMemory,
  input  wire [HeapAddressBits-1:0]       newArray,
  input  wire [HeapDataBits-1:0]          readValue,
  input  wire [HeapDataBits-1:0]          topValue,
  input  wire [HeapDataBits-1:0]          newValue,
  input  wire [HeapDataBits-1:0]          returnValue,
  output logic [HeapDataBits-1:0]         result,
  output heapError_t                      error,
  output logic                            allocCommit,
  output logic                            sizeCommit,
  output logic                            storeWrite,
  output logic [HeapIndexBits-1:0]        writeIndex,
  output logic [HeapDataBits-1:0]         writeValue,
  output logic [HeapIndexBits-1:0]        topIndex
);

  heapAction_t             action;
  logic                    isElementOp;
  logic                    needsArray;                     // Array must be live
  logic                    ok;
  logic                    hasResult;
  heapError_t              nextError;
  logic [HeapDataBits-1:0] nextResult;

  assign action      = request.action;
  assign isElementOp = action inside {actAdd, actAddAfter, actSub, actSubAfter, actShl,
                                      actShr, actNotLogical, actNot, actOr, actXor, actAnd};
  assign needsArray  = !(action inside {actIdle, actReset, actAlloc});

  // Error priority --------------------
  always_comb begin
    nextError = errNone;
    if (needsArray && arrayStatus.notAllocated) nextError = errNotAllocated;
    else if (needsArray && arrayStatus.freed)   nextError = errFreed;
    else if ((isElementOp || action == actRead) && !sizeStatus.inBounds)
      nextError = errOutOfBounds;
    else if ((action == actDec || action == actPop) && sizeStatus.empty)
      nextError = errEmpty;
    else if ((action == actInc || action == actPush) && sizeStatus.full)
      nextError = errFull;
    else if (action == actResize && request.data > ArrayLength)
      nextError = errTooLarge;
    else if (action == actAlloc && outOfMemory)
      nextError = errOutOfMemory;
  end

  assign ok = (action != actIdle) && (nextError == errNone);

  // Commit gating --------------------
  assign allocCommit = ok && (action inside {actReset, actAlloc, actFree});
  assign sizeCommit  = ok && (action inside {actReset, actWrite, actInc, actDec, actPush,
                                             actPop, actResize, actAlloc});
  assign storeWrite  = ok && (isElementOp || action == actWrite || action == actPush);

  assign writeIndex = (action == actPush) ? sizeStatus.size[HeapIndexBits-1:0]  // Next free slot
                                          : request.index;
  assign writeValue = isElementOp ? newValue : request.data;
  assign topIndex   = sizeStatus.size[HeapIndexBits-1:0] - 1'b1;

  always_comb begin
    hasResult  = 1'b1;
    nextResult = result;
    case (action)
      actWrite: nextResult = request.data;
      actRead:  nextResult = readValue;
      actSize:  nextResult = HeapDataBits'(sizeStatus.size);
      actPop:   nextResult = topValue;
      actAlloc: nextResult = HeapDataBits'(newArray);
      default: begin
        hasResult  = isElementOp;
        nextResult = returnValue;
      end
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      result <= '0;
      error  <= errNone;
    end else if (action != actIdle) begin
      error <= nextError;
      if (ok && hasResult) result <= nextResult;
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) !$isunknown(error));

endmodule

`default_nettype wire

/* src/elementAlu.sv */
/*
  Read-modify-write arithmetic for the element operations.
  All results wrap at 12 bits. Shift counts come from data.
*/
`default_nettype none

module elementAlu import heapPkg::*; (
  input  wire heapRequest_t           request,
  input  wire [HeapDataBits-1:0]      readValue,
  output logic [HeapDataBits-1:0]     newValue,
  output logic [HeapDataBits-1:0]     returnValue
);

  logic [HeapDataBits-1:0] operand;
  logic                    returnsOld;

  assign operand = request.data;

  always_comb begin
    case (request.action)
      actAdd, actAddAfter: newValue = readValue + operand;   // Wraps
      actSub, actSubAfter: newValue = readValue - operand;
      actShl:              newValue = readValue << operand;
      actShr:              newValue = readValue >> operand;
      actNotLogical:       newValue = (readValue == '0) ? HeapDataBits'(1) : '0;
      actNot:              newValue = ~readValue;
      actOr:               newValue = readValue | operand;
      actXor:              newValue = readValue ^ operand;
      actAnd:              newValue = readValue & operand;
      default:             newValue = readValue;             // Not an element op
    endcase
  end

  // After forms hand back the value before the update
  assign returnsOld  = (request.action == actAddAfter) || (request.action == actSubAfter);
  assign returnValue = returnsOld ? readValue : newValue;

endmodule

`default_nettype wire

/* src/elementStore.sv */
/*
  Element memory of every array, in fixed blocks.
  Reads are combinational, the write lands at the clock edge.
  Contents survive both reset and the reset action.
*/
`default_nettype none

module elementStore import heapPkg::*; (
  input  wire                             clock,
  input  wire heapRequest_t               request,
  input  wire                             storeWrite,
  input  wire [HeapIndexBits-1:0]         writeIndex,
  input  wire [HeapDataBits-1:0]          writeValue,
  output logic [HeapDataBits-1:0]         readValue,
  output logic [HeapDataBits-1:0]         topValue,
  input  wire [HeapIndexBits-1:0]         topIndex
);

  logic [HeapDataBits-1:0] memory [HeapArrays][ArrayLength];

  // Both read ports address the requested array
  assign readValue = memory[request.array][request.index];
  assign topValue  = memory[request.array][topIndex];      // Element under the top for pop

  always_ff @(posedge clock) begin
    if (storeWrite)
      memory[request.array][writeIndex] <= writeValue;
  end

endmodule

`default_nettype wire

/* src/arraySizeTable.sv */
/*
  Current size of every array.
  Alloc zeroes the size of the array being handed out, not the requested one.
*/
`default_nettype none

module arraySizeTable import heapPkg::*; (
  input  wire                              clock,
  input  wire                              resetN,
  input  wire heapRequest_t                request,
  input  wire                              sizeCommit,
  input  wire [HeapAddressBits-1:0]        newArray,
  output sizeStatus_t                      sizeStatus
);

  logic [HeapIndexBits:0] sizes [HeapArrays];
  logic [HeapIndexBits:0] curSize;
  logic [HeapIndexBits:0] writeEnd;                        // Index plus one
  logic [HeapIndexBits:0] nextSize;

  assign curSize  = sizes[request.array];
  assign writeEnd = {1'b0, request.index} + 1'b1;

  assign sizeStatus.size     = curSize;
  assign sizeStatus.empty    = curSize == '0;
  assign sizeStatus.full     = curSize == ArrayLength;
  assign sizeStatus.inBounds = {1'b0, request.index} < curSize;

  // Size update --------------------
  always_comb begin
    case (request.action)
      actWrite:        nextSize = (writeEnd > curSize) ? writeEnd : curSize;
      actPush, actInc: nextSize = curSize + 1'b1;
      actPop, actDec:  nextSize = curSize - 1'b1;
      actResize:       nextSize = request.data[HeapIndexBits:0];  // Already bounded
      default:         nextSize = curSize;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < HeapArrays; a++) sizes[a] <= '0;
    end else if (sizeCommit) begin
      if (request.action == actReset) begin
        for (int a = 0; a < HeapArrays; a++) sizes[a] <= '0;
      end else if (request.action == actAlloc) begin
        sizes[newArray] <= '0;                             // Fresh array starts empty
      end else begin
        sizes[request.array] <= nextSize;
      end
    end
  end

  for (genvar g = 0; g < HeapArrays; g++) begin : gSizeLimit
    assert property (@(posedge clock) disable iff (!resetN) sizes[g] <= ArrayLength);
  end

endmodule

`default_nettype wire

/* src/arrayAllocator.sv */
/*
  Hands out array numbers, reusing freed ones last-in first-out.
  Status outputs are combinational on the requested array.
  Commits only when allocCommit is high for reset, alloc or free.
*/
`default_nettype none

module arrayAllocator import heapPkg::*; (
  input  wire                         clock,
  input  wire                         resetN,
  input  wire heapRequest_t           request,
  input  wire                         allocCommit,
  output arrayStatus_t                arrayStatus,
  output logic [HeapAddressBits-1:0]  newArray,
  output logic                        outOfMemory
);

  logic [HeapAddressBits:0]    allocatedCount;             // High-water mark
  logic [HeapArrays-1:0]       allocated;                  // One flag per array
  logic [HeapAddressBits-1:0]  freedStack [HeapArrays];
  logic [HeapAddressBits:0]    freedTop;                   // Entries on the freed stack
  logic [HeapAddressBits-1:0]  topSlot;

  assign topSlot = freedTop[HeapAddressBits-1:0] - 1'b1;

  // Lookups --------------------
  assign arrayStatus.notAllocated = {1'b0, request.array} >= allocatedCount;
  assign arrayStatus.freed        = !allocated[request.array];

  // Freed arrays come back before fresh ones
  assign newArray    = (freedTop != '0) ? freedStack[topSlot]
                                        : allocatedCount[HeapAddressBits-1:0];
  assign outOfMemory = (freedTop == '0) && (allocatedCount == HeapArrays);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocatedCount <= '0;
      allocated      <= '0;
      freedTop       <= '0;
    end else if (allocCommit) begin
      case (request.action)
        actReset: begin
          allocatedCount <= '0;
          allocated      <= '0;
          freedTop       <= '0;
        end
        actAlloc: begin
          if (freedTop != '0) freedTop <= freedTop - 1'b1;
          else allocatedCount <= allocatedCount + 1'b1;
          allocated[newArray] <= 1'b1;
        end
        actFree: begin
          freedTop                   <= freedTop + 1'b1;
          allocated[request.array]   <= 1'b0;   // No longer live
        end
        default: ;
      endcase
    end
  end

  // Freed array numbers in push order
  always_ff @(posedge clock) begin
    if (allocCommit && request.action == actFree)
      freedStack[freedTop[HeapAddressBits-1:0]] <= request.array;
  end

  // A double free would overflow the stack
  assert property (@(posedge clock) disable iff (!resetN) freedTop <= HeapArrays);

endmodule

`default_nettype wire

/* src/heapPkg.sv */
/*
  Shared widths, action and error codes for the array heap.
  Four arrays of four 12-bit elements. Change widths here only.
*/
`default_nettype none

package heapPkg;

  // Geometry --------------------
  localparam integer HeapAddressBits = 2;                 // Bits in an array number
  localparam integer HeapIndexBits   = 2;                 // Bits in an element index
  localparam integer HeapDataBits    = 12;                // Element width
  localparam integer HeapArrays      = 2 ** HeapAddressBits;
  localparam integer ArrayLength     = 2 ** HeapIndexBits;

  // Action codes with zero as no command
  typedef enum logic [7:0] {
    actIdle       = 8'd0,
    actReset      = 8'd1,
    actWrite      = 8'd2,
    actRead       = 8'd3,
    actSize       = 8'd4,
    actInc        = 8'd5,
    actDec        = 8'd6,
    actPush       = 8'd14,
    actPop        = 8'd15,
    actResize     = 8'd17,
    actAlloc      = 8'd18,
    actFree       = 8'd19,
    actAdd        = 8'd20,
    actAddAfter   = 8'd21,
    actSub        = 8'd22,
    actSubAfter   = 8'd23,
    actShl        = 8'd24,
    actShr        = 8'd25,
    actNotLogical = 8'd26,
    actNot        = 8'd27,
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction_t;

  typedef enum logic [3:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds,
    errEmpty, errFull, errTooLarge, errOutOfMemory
  } heapError_t;

  // Bundles --------------------
  typedef struct packed {
    heapAction_t                 action;
    logic [HeapAddressBits-1:0]  array;
    logic [HeapIndexBits-1:0]    index;
    logic [HeapDataBits-1:0]     data;
  } heapRequest_t;

  typedef struct packed {
    logic [HeapIndexBits:0] size;                          // 0 to ArrayLength
    logic                   empty;
    logic                   full;
    logic                   inBounds;                      // Index below size
  } sizeStatus_t;

  typedef struct packed {
    logic notAllocated;                                    // Above high-water count
    logic freed;                                           // Allocation flag clear
  } arrayStatus_t;

endpackage

`default_nettype wire
